/* design/issue_cfg.svh */
// Sizing defines for the issue stage, included by the package and by the RTL that sizes arrays
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// In-flight table depth, must be a power of two
`define ISSUE_ENTRIES 8

// Register index width for both units
`define IDX_WIDTH 5

`endif

/* design/issuePkg.sv */
// Instruction, operand and table types shared by the issue stage RTL and its testbench
`include "issue_cfg.svh"

package issuePkg;

	//////////////////////////////
	// Instruction word
	//////////////////////////////

	typedef struct packed {
		logic                   valid;
		logic [`IDX_WIDTH-1:0]  index;
	} operand_t;

	typedef struct packed {
		logic [1:0] opType;
		logic [1:0] opClass;
		logic [1:0] opCode;
		logic [3:0] sliceLen;     // Zero means not sliced
		operand_t   dst;
		operand_t   src1;
		operand_t   src2;
		operand_t   src3;
	} regForm_t;

	typedef struct packed {
		logic [1:0]  opType;
		logic [1:0]  opClass;
		logic [1:0]  opCode;
		logic [27:0] target;      // Branch offset, not used here
	} brForm_t;

	// Same 34 bits, read either way
	typedef union packed {
		regForm_t regForm;
		brForm_t  brForm;
	} instrWord_u;

	//////////////////////////////
	// Table side
	//////////////////////////////

	typedef struct packed {
		logic                   valid;
		logic                   unit;     // Vector is 1
		logic [`IDX_WIDTH-1:0]  index;
	} regIndex_t;

	typedef struct packed {
		logic raw;
		logic war;
		logic waw;
		logic rar;
	} hazard_t;

	typedef struct packed {
		logic       valid;
		logic       branch;
		logic [3:0] sliceLen;
		regIndex_t  dst;
		regIndex_t  src1;
		regIndex_t  src2;
		regIndex_t  src3;
	} entry_t;

	typedef logic [$clog2(`ISSUE_ENTRIES)-1:0] tag_t;

endpackage

/* design/issueRing.sv */
// Ring pointer counter that hands out issue tags and tracks table occupancy for the hazard table
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issueRing (
	input  logic           clock,
	input  logic           reset,
	input  logic           advanceWrite,   // Accept of a new instruction
	input  logic           advanceRead,    // Retire of the oldest entry
	output issuePkg::tag_t writeTag,
	output issuePkg::tag_t readTag,
	output logic           notFull,
	output logic           empty
);

	localparam int CountWidth = $clog2(`ISSUE_ENTRIES) + 1;

	issuePkg::tag_t        writePtr;
	issuePkg::tag_t        readPtr;
	logic [CountWidth-1:0] count;

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end else begin
			if (advanceWrite)
				writePtr <= writePtr + 1'b1;
			if (advanceRead)
				readPtr <= readPtr + 1'b1;
			case ({advanceWrite, advanceRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Both or neither
			endcase
		end
	end

	assign writeTag = writePtr;
	assign readTag  = readPtr;
	assign notFull  = (count != CountWidth'(`ISSUE_ENTRIES));
	assign empty    = (count == '0);

endmodule

/* design/hazardTable.sv */
// In-flight instruction table that checks requests for hazards and registers the issue outputs
`timescale 1ns/1ps
`include "issue_cfg.svh"

module hazardTable (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 request,
	input  issuePkg::instrWord_u instr,
	input  logic                 isVec,
	input  logic                 slice,
	input  logic                 commit,
	input  logic                 notFull,
	input  logic                 empty,
	input  logic                 block,
	input  issuePkg::tag_t       writeTag,
	input  issuePkg::tag_t       readTag,
	output logic                 accept,
	output logic                 retire,
	output logic                 branchIssued,
	output logic                 branchRetired,
	output logic                 issueValid,
	output issuePkg::instrWord_u issueInstr,
	output issuePkg::tag_t       issueTag,
	output issuePkg::hazard_t    hazards
);

	issuePkg::entry_t    inflight [`ISSUE_ENTRIES];

	logic                isBranch;
	logic                canIssue;
	issuePkg::regIndex_t inDst;
	issuePkg::regIndex_t inSrc1;
	issuePkg::regIndex_t inSrc2;
	issuePkg::regIndex_t inSrc3;
	issuePkg::hazard_t   match;
	issuePkg::entry_t    newEntry;

	// Both valid and equal with the unit bit included
	function automatic logic sameReg(issuePkg::regIndex_t a, issuePkg::regIndex_t b);
		return a.valid & b.valid & (a == b);
	endfunction

	function automatic logic anySrc(issuePkg::regIndex_t a, issuePkg::entry_t e);
		return sameReg(a, e.src1) | sameReg(a, e.src2) | sameReg(a, e.src3);
	endfunction

	function automatic issuePkg::regIndex_t toIndex(issuePkg::operand_t op, logic vec,
		logic enable);
		return '{valid: op.valid & enable, unit: vec, index: op.index};
	endfunction

	//////////////////////////////
	// Decode
	//////////////////////////////

	assign isBranch = (instr.brForm.opType == 2'd2) && (instr.brForm.opClass == 2'd1)
		&& (instr.brForm.opCode == 2'd1);

	// Branch bits overlay the operand fields and are ignored
	assign inDst  = toIndex(instr.regForm.dst,  isVec, ~isBranch);
	assign inSrc1 = toIndex(instr.regForm.src1, isVec, ~isBranch);
	assign inSrc2 = toIndex(instr.regForm.src2, isVec, ~isBranch);
	assign inSrc3 = toIndex(instr.regForm.src3, isVec, ~isBranch);

	always_comb begin
		match = '0;
		for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
			if (inflight[i].valid) begin
				match.raw = match.raw | sameReg(inSrc1, inflight[i].dst)
					| sameReg(inSrc2, inflight[i].dst) | sameReg(inSrc3, inflight[i].dst);
				match.war = match.war | anySrc(inDst, inflight[i]);
				match.waw = match.waw | sameReg(inDst, inflight[i].dst);
				if (inflight[i].sliceLen != '0) begin
					match.rar = match.rar | anySrc(inSrc1, inflight[i])
						| anySrc(inSrc2, inflight[i]) | anySrc(inSrc3, inflight[i]);
				end
			end
		end
		match.rar = match.rar & slice;   // Reads only collide when slicing
	end

	// RAR is reported but never holds an instruction back
	assign canIssue = request & ~(match.raw | match.war | match.waw) & notFull & ~block;
	assign accept   = canIssue;
	assign retire   = commit & ~empty;

	assign branchIssued  = accept & isBranch;
	assign branchRetired = retire & inflight[readTag].branch;

	assign newEntry = '{
		valid:    1'b1,
		branch:   isBranch,
		sliceLen: isBranch ? 4'd0 : instr.regForm.sliceLen,
		dst:      inDst,
		src1:     inSrc1,
		src2:     inSrc2,
		src3:     inSrc3
	};

	//////////////////////////////
	// Table and outputs
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ISSUE_ENTRIES; i++)
				inflight[i].valid <= 1'b0;
		end else begin
			if (retire)
				inflight[readTag].valid <= 1'b0;   // Head entry leaves
			if (accept)
				inflight[writeTag] <= newEntry;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid <= 1'b0;
			hazards    <= '0;
		end else begin
			issueValid <= accept;
			hazards    <= request ? match : '0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			issueInstr <= instr;
			issueTag   <= writeTag;
		end
	end

endmodule

/* design/branchStall.sv */
// Branch stall FSM that blocks further issue from a branch's issue until that branch commits
`timescale 1ns/1ps

module branchStall (
	input  logic clock,
	input  logic reset,
	input  logic branchIssued,    // Pulse, a branch was accepted
	input  logic branchRetired,   // Pulse, a branch entry was retired
	output logic block
);

	typedef enum logic {
		Run,
		Stall
	} state_t;

	state_t state;
	state_t nextState;

	always_comb begin
		nextState = state;
		case (state)
			Run: begin
				if (branchIssued)
					nextState = Stall;
			end
			Stall: begin
				// Only one branch can be in flight
				if (branchRetired)
					nextState = Run;
			end
			default: nextState = Run;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= Run;
		else
			state <= nextState;
	end

	assign block = (state == Stall);

endmodule

/* design/issueStage.sv */
// Issue stage top that ties the hazard table to its tag ring and branch stall FSM
`timescale 1ns/1ps

module issueStage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 request,    // Held until issued
	input  issuePkg::instrWord_u instr,
	input  logic                 isVec,
	input  logic                 slice,
	input  logic                 commit,     // One-cycle pulse
	output logic                 issueValid,
	output issuePkg::instrWord_u issueInstr,
	output issuePkg::tag_t       issueTag,
	output issuePkg::hazard_t    hazards,
	output logic                 stalled
);

	logic           accept;
	logic           retire;
	logic           branchIssued;
	logic           branchRetired;
	logic           notFull;
	logic           empty;
	logic           block;
	issuePkg::tag_t writeTag;
	issuePkg::tag_t readTag;

	hazardTable table0 (
		.clock         (clock),
		.reset         (reset),
		.request       (request),
		.instr         (instr),
		.isVec         (isVec),
		.slice         (slice),
		.commit        (commit),
		.notFull       (notFull),
		.empty         (empty),
		.block         (block),
		.writeTag      (writeTag),
		.readTag       (readTag),
		.accept        (accept),
		.retire        (retire),
		.branchIssued  (branchIssued),
		.branchRetired (branchRetired),
		.issueValid    (issueValid),
		.issueInstr    (issueInstr),
		.issueTag      (issueTag),
		.hazards       (hazards)
	);

	issueRing ring0 (
		.clock        (clock),
		.reset        (reset),
		.advanceWrite (accept),
		.advanceRead  (retire),
		.writeTag     (writeTag),
		.readTag      (readTag),
		.notFull      (notFull),
		.empty        (empty)
	);

	branchStall stall0 (
		.clock         (clock),
		.reset         (reset),
		.branchIssued  (branchIssued),
		.branchRetired (branchRetired),
		.block         (block)
	);

	assign stalled = block;

endmodule

/* tb/issueStage_asserts.sv */
// Concurrent checks on the issue, commit and stall rules, bound into the issue stage top
`timescale 1ns/1ps

module issueStage_asserts (
	input logic           clock,
	input logic           reset,
	input logic           commit,
	input logic           empty,
	input logic           issueValid,
	input issuePkg::tag_t issueTag,
	input logic           stalled
);

	issuePkg::tag_t lastTag;
	int unsigned    failures = 0;

	always_ff @(posedge clock) begin
		if (reset)
			lastTag <= '1;   // First issue lands on tag 0
		else if (issueValid)
			lastTag <= issueTag;
	end

	stallHoldsIssue: assert property (@(posedge clock) disable iff (reset)
		stalled |=> !issueValid) else begin
		$error("Issue right after a stalled cycle");
		failures++;
	end

	tagSteps: assert property (@(posedge clock) disable iff (reset)
		issueValid |-> issueTag == issuePkg::tag_t'(lastTag + 1'b1)) else begin
		$error("Issue tag did not advance by one");
		failures++;
	end

	commitNeedsEntry: assert property (@(posedge clock) disable iff (reset)
		commit |-> !empty) else begin
		$error("Commit while the table is empty");
		failures++;
	end

endmodule

bind issueStage issueStage_asserts checks (
	.clock      (clock),
	.reset      (reset),
	.commit     (commit),
	.empty      (empty),
	.issueValid (issueValid),
	.issueTag   (issueTag),
	.stalled    (stalled)
);

/* tb/issueStageTb.sv */
// Table-driven testbench for the issue stage, run with the file list as top module issueStageTb
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issueStageTb;

	typedef struct packed {
		logic                 request;
		issuePkg::instrWord_u instr;
		logic                 isVec;
		logic                 slice;
		logic                 commit;
		logic                 expValid;
		issuePkg::tag_t       expTag;
		issuePkg::hazard_t    expHaz;
		logic                 expStalled;
	} row_t;

	localparam issuePkg::hazard_t NoHaz = '0;
	localparam issuePkg::hazard_t Raw   = '{raw: 1'b1, default: 1'b0};
	localparam issuePkg::hazard_t War   = '{war: 1'b1, default: 1'b0};
	localparam issuePkg::hazard_t Waw   = '{waw: 1'b1, default: 1'b0};
	localparam issuePkg::hazard_t Rar   = '{rar: 1'b1, default: 1'b0};

	logic                 clock;
	logic                 reset;
	logic                 request;
	issuePkg::instrWord_u instr;
	logic                 isVec;
	logic                 slice;
	logic                 commit;
	logic                 issueValid;
	issuePkg::instrWord_u issueInstr;
	issuePkg::tag_t       issueTag;
	issuePkg::hazard_t    hazards;
	logic                 stalled;

	row_t rows[$];
	int   cycles = 0;
	int   cycleLimit = 1000;

	issueStage UUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Overall limit, set from the table length
	always @(posedge clock) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout: run did not end within %0d cycles", cycleLimit);
			$display("Regression failed");
			$fatal(1, "Timeout");
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Register form with dst and src1 only
	function automatic issuePkg::instrWord_u regOp(int dst, int src1, logic [3:0] sliceLen);
		issuePkg::regForm_t   f;
		issuePkg::instrWord_u w;
		f = '0;
		f.sliceLen = sliceLen;
		f.dst      = '{valid: 1'b1, index: `IDX_WIDTH'(dst)};
		f.src1     = '{valid: 1'b1, index: `IDX_WIDTH'(src1)};
		w.regForm  = f;
		return w;
	endfunction

	function automatic issuePkg::instrWord_u branchOp();
		issuePkg::instrWord_u w;
		w.brForm = '{opType: 2'd2, opClass: 2'd1, opCode: 2'd1, target: 28'h0a5c3f1};
		return w;
	endfunction

	task automatic addRow(input logic req, input issuePkg::instrWord_u in, input logic vec,
		input logic sl, input logic cm, input logic v, input int tag,
		input issuePkg::hazard_t hz, input logic st);
		rows.push_back('{req, in, vec, sl, cm, v, issuePkg::tag_t'(tag), hz, st});
	endtask

	task automatic checkValue(input string name, input logic [33:0] actual,
		input logic [33:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Regression failed");
			$fatal(1, "First mismatch");
		end
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	initial begin
		row_t r;
		request = 1'b0;
		instr   = '0;
		isVec   = 1'b0;
		slice   = 1'b0;
		commit  = 1'b0;
		reset   = 1'b1;

		for (int i = 0; i < 8; i++)   // Fill, tags 0 to 7
			addRow(1, regOp(i + 1, i + 16, 0), 0, 0, 0, 1, i, NoHaz, 0);
		addRow(1, regOp(9, 24, 0), 0, 0, 0, 0, 0, NoHaz, 0);    // Full, waits
		addRow(1, regOp(9, 24, 0), 0, 0, 1, 0, 0, NoHaz, 0);
		addRow(1, regOp(9, 24, 0), 0, 0, 0, 1, 0, NoHaz, 0);    // Wrapped tag
		for (int i = 0; i < 8; i++)
			addRow(0, '0, 0, 0, 1, 0, 0, NoHaz, 0);
		addRow(1, regOp(5, 6, 0), 0, 0, 0, 1, 1, NoHaz, 0);
		addRow(1, regOp(8, 5, 0), 1, 0, 0, 1, 2, NoHaz, 0);     // Vector r5 is a different reg
		addRow(1, regOp(7, 5, 0), 0, 0, 0, 0, 0, Raw, 0);
		addRow(1, regOp(7, 5, 0), 0, 0, 1, 0, 0, Raw, 0);       // Old table still seen
		addRow(1, regOp(7, 5, 0), 0, 0, 0, 1, 3, NoHaz, 0);
		addRow(1, regOp(5, 9, 0), 0, 0, 0, 0, 0, War, 0);
		addRow(1, regOp(5, 9, 0), 0, 0, 1, 0, 0, War, 0);
		addRow(1, regOp(5, 9, 0), 0, 0, 1, 0, 0, War, 0);
		addRow(1, regOp(5, 9, 0), 0, 0, 0, 1, 4, NoHaz, 0);
		addRow(1, regOp(5, 10, 0), 0, 0, 0, 0, 0, Waw, 0);
		addRow(1, regOp(5, 10, 0), 0, 0, 1, 0, 0, Waw, 0);
		addRow(1, regOp(5, 10, 0), 0, 0, 0, 1, 5, NoHaz, 0);
		addRow(1, regOp(11, 12, 4), 0, 1, 0, 1, 6, NoHaz, 0);   // Sliced reader
		addRow(1, regOp(13, 12, 0), 0, 1, 0, 1, 7, Rar, 0);
		addRow(1, regOp(14, 10, 0), 0, 1, 0, 1, 0, NoHaz, 0);   // Unsliced entry, no RAR
		addRow(1, regOp(15, 12, 0), 0, 0, 0, 1, 1, NoHaz, 0);   // Slice off
		for (int i = 0; i < 5; i++)
			addRow(0, '0, 0, 0, 1, 0, 0, NoHaz, 0);
		addRow(1, branchOp(), 0, 0, 0, 1, 2, NoHaz, 1);
		addRow(1, regOp(16, 17, 0), 0, 0, 0, 0, 0, NoHaz, 1);
		addRow(1, regOp(16, 17, 0), 0, 0, 1, 0, 0, NoHaz, 0);   // Branch retires
		addRow(1, regOp(16, 17, 0), 0, 0, 0, 1, 3, NoHaz, 0);
		addRow(0, '0, 0, 0, 1, 0, 0, NoHaz, 0);
		cycleLimit = 2 * rows.size() + 20;

		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		checkValue("issueValid", issueValid, 0);
		checkValue("stalled", stalled, 0);
		checkValue("hazards", hazards, 0);

		foreach (rows[k]) begin
			r       = rows[k];
			request = r.request;
			instr   = r.instr;
			isVec   = r.isVec;
			slice   = r.slice;
			commit  = r.commit;
			@(posedge clock);
			#1;
			checkValue("issueValid", issueValid, r.expValid);
			checkValue("hazards", hazards, r.expHaz);
			checkValue("stalled", stalled, r.expStalled);
			if (r.expValid) begin
				checkValue("issueTag", issueTag, r.expTag);
				checkValue("issueInstr", issueInstr, r.instr);
			end
		end

		if (UUT.checks.failures == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", UUT.checks.failures);
			$display("Regression failed");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

/* issueStage.f */
+incdir+design
design/issuePkg.sv
design/issueRing.sv
design/hazardTable.sv
design/branchStall.sv
design/issueStage.sv
tb/issueStage_asserts.sv
tb/issueStageTb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module issueStageTb \
	-f issueStage.f -o issueSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/issueSim +verilator+error+limit+100 > sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "PASS" \
	|| { cat sim.log; echo "FAIL"; exit 1; }
